//--- Makefile
SIM        = verilator
TOP        = camera_filter_tb
FILELIST   = compile.f
SIM_FLAGS  = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = === PASS ===

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q -F -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+hw
hw/video_pkg.sv
hw/mem_pkg.sv
hw/video_ifs.sv
hw/ov7670_capture.sv
hw/frame_buffer.sv
hw/address_generator.sv
hw/filter_select.sv
hw/filter_control.sv
hw/camera_filter_top.sv
verification/camera_filter_tb.sv

//--- hw/address_generator.sv
// Frame readout that turns buffer reads into a framed pixel packet
`include "video_defs.svh"

module address_generator import video_pkg::*; import mem_pkg::*; (
	input  logic          clk_50,
	input  logic          rst_n,
	input  logic          frame_done,  // Capture finished a frame
	fb_port_if.client     mem,
	pix_stream_if.source  out_stream
);

	localparam fb_addr_t LAST_ADDR = fb_addr_t'(`FRAME_W * `FRAME_H - 1);

	logic     busy_q;      // Frame in progress
	logic     rd_done_q;   // All reads issued
	fb_addr_t rd_addr_q;   // Next read address
	logic     fly_q;       // Read data returns this cycle
	logic     fly_sop_q;
	logic     fly_eop_q;
	rgb444_t  pix_q;       // Output pixel register
	logic     sop_q;
	logic     eop_q;
	logic     valid_q;
	logic     take;        // Output beat accepted
	logic     rd_fire;

	assign take    = valid_q && out_stream.ready;
	assign mem.req = busy_q && !rd_done_q && !fly_q && (!valid_q || out_stream.ready);
	assign rd_fire = mem.req && mem.gnt;  // Capture may deny
	assign mem.we    = 1'b0;              // Read-only client
	assign mem.addr  = rd_addr_q;
	assign mem.wdata = '0;

	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			busy_q    <= 1'b0;
			rd_done_q <= 1'b0;
			rd_addr_q <= '0;
			fly_q     <= 1'b0;
			fly_sop_q <= 1'b0;
			fly_eop_q <= 1'b0;
			valid_q   <= 1'b0;
			sop_q     <= 1'b0;
			eop_q     <= 1'b0;
		end else begin
			if (!busy_q && frame_done) begin  // Ignored while streaming
				busy_q    <= 1'b1;
				rd_done_q <= 1'b0;
				rd_addr_q <= '0;
			end else if (take && eop_q) begin
				busy_q <= 1'b0;
			end else if (rd_fire) begin
				rd_done_q <= (rd_addr_q == LAST_ADDR);
				rd_addr_q <= rd_addr_q + 1'b1;
			end
			fly_q     <= rd_fire;
			fly_sop_q <= (rd_addr_q == '0);
			fly_eop_q <= (rd_addr_q == LAST_ADDR);
			if (fly_q) begin                  // Register is free by construction
				valid_q <= 1'b1;
				sop_q   <= fly_sop_q;
				eop_q   <= fly_eop_q;
			end else if (take) begin
				valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_50) begin
		if (fly_q)
			pix_q <= rgb444_t'(mem.rdata);
	end

	assign out_stream.data  = pix_q;
	assign out_stream.sop   = sop_q;
	assign out_stream.eop   = eop_q;
	assign out_stream.valid = valid_q;

	// Stalled beat stays put until accepted
	a_hold_stall: assert property (@(posedge clk_50) disable iff (!rst_n)
		out_stream.valid && !out_stream.ready |=> out_stream.valid &&
		$stable(out_stream.data) && $stable(out_stream.sop) && $stable(out_stream.eop));

endmodule

//--- hw/camera_filter_top.sv
// Camera to display video path with selectable pixel filter
module camera_filter_top import video_pkg::*; (
	input  logic        clk_50,
	input  logic        rst_n,
	input  logic [3:0]  key,          // Filter select buttons
	input  logic        cam_vsync,
	input  logic        cam_href,
	input  logic [7:0]  cam_data,
	output logic [11:0] pix_data,     // RGB444
	output logic        pix_sop,
	output logic        pix_eop,
	output logic        pix_valid,
	input  logic        pix_ready,    // Sink back-pressure
	output logic [1:0]  filter_mode
);

	fb_port_if    cap_port ();      // Capture to memory
	fb_port_if    rd_port ();       // Memory to readout
	pix_stream_if raw_stream ();    // Readout to filter

	filter_e mode_w;
	logic    frame_done;

	assign filter_mode = mode_w;

	filter_control ctrl_i (
		.clk_50      (clk_50),
		.rst_n       (rst_n),
		.key         (key),
		.filter_type (mode_w)
	);

	ov7670_capture cap_i (
		.clk_50     (clk_50),
		.rst_n      (rst_n),
		.vsync      (cam_vsync),
		.href       (cam_href),
		.data       (cam_data),
		.mem        (cap_port.client),
		.frame_done (frame_done)
	);

	frame_buffer fb_i (
		.clk_50   (clk_50),
		.rst_n    (rst_n),
		.cap_port (cap_port.memory),
		.rd_port  (rd_port.memory)
	);

	address_generator ag_i (
		.clk_50     (clk_50),
		.rst_n      (rst_n),
		.frame_done (frame_done),
		.mem        (rd_port.client),
		.out_stream (raw_stream.source)
	);

	filter_select fs_i (
		.clk_50      (clk_50),
		.rst_n       (rst_n),
		.filter_type (mode_w),
		.in_stream   (raw_stream.sink),
		.data_out    (pix_data),
		.sop_out     (pix_sop),
		.eop_out     (pix_eop),
		.valid_out   (pix_valid),
		.ready_in    (pix_ready)
	);

endmodule

//--- hw/filter_control.sv
// Key-driven filter mode selection from active-low push buttons
module filter_control import video_pkg::*; (
	input  logic       clk_50,
	input  logic       rst_n,
	input  logic [3:0] key,         // Active low
	output filter_e    filter_type
);

	logic [3:0] key_s;  // Sampled keys
	logic [3:0] key_q;  // Previous sample
	logic [3:0] fall;   // Press events

	assign fall = key_q & ~key_s;

	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			key_s       <= 4'hf;       // Released
			key_q       <= 4'hf;
			filter_type <= FILT_PASS;
		end else begin
			key_s <= key;
			key_q <= key_s;
			if (fall[0])
				filter_type <= FILT_PASS;  // Lowest index wins
			else if (fall[1])
				filter_type <= FILT_GRAY;
			else if (fall[2])
				filter_type <= FILT_INVERT;
			else if (fall[3])
				filter_type <= FILT_THRESH;
		end
	end

endmodule

//--- hw/filter_select.sv
// Registered per-pixel filter with the mode held for a whole frame
`include "video_defs.svh"

module filter_select import video_pkg::*; (
	input  logic         clk_50,
	input  logic         rst_n,
	input  filter_e      filter_type,  // Requested mode
	pix_stream_if.sink   in_stream,
	output rgb444_t      data_out,
	output logic         sop_out,
	output logic         eop_out,
	output logic         valid_out,
	input  logic         ready_in      // Downstream sink ready
);

	filter_e mode_q;   // Mode of the current frame
	filter_e mode_use; // Mode for the incoming beat
	logic    accept;
	rgb444_t pix_f;

	// Luma approximation (r + 2g + b) / 4
	function automatic logic [3:0] gray_of(input rgb444_t px);
		logic [5:0] sum;
		sum = {2'b00, px.r} + {1'b0, px.g, 1'b0} + {2'b00, px.b};
		return sum[5:2];
	endfunction

	function automatic rgb444_t apply(input filter_e mode, input rgb444_t px);
		logic [3:0] g;
		rgb444_t    res;
		g = gray_of(px);
		case (mode)
			FILT_GRAY:   res = '{r: g, g: g, b: g};
			FILT_INVERT: res = ~px;
			FILT_THRESH: res = (g >= `GRAY_THRESH) ? 12'hfff : 12'h000;
			default:     res = px;  // Pass
		endcase
		return res;
	endfunction

	assign in_stream.ready = ready_in || !valid_out;      // Slot free or draining
	assign accept   = in_stream.valid && in_stream.ready;
	assign mode_use = (accept && in_stream.sop) ? filter_type : mode_q;  // New frame takes key
	assign pix_f    = apply(mode_use, in_stream.data);

	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			mode_q    <= FILT_PASS;
			valid_out <= 1'b0;
			sop_out   <= 1'b0;
			eop_out   <= 1'b0;
		end else begin
			if (accept && in_stream.sop)
				mode_q <= filter_type;  // Latched per frame
			if (accept) begin
				valid_out <= 1'b1;
				sop_out   <= in_stream.sop;
				eop_out   <= in_stream.eop;
			end else if (ready_in) begin
				valid_out <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_50) begin
		if (accept)
			data_out <= pix_f;
	end

endmodule

//--- hw/frame_buffer.sv
// Shared single-port frame memory with capture-first arbitration
`include "video_defs.svh"

module frame_buffer import mem_pkg::*; (
	input  logic       clk_50,
	input  logic       rst_n,
	fb_port_if.memory  cap_port,  // Camera writer
	fb_port_if.memory  rd_port    // Frame reader
);

	fb_word_t   mem_q [`FB_DEPTH];
	fb_word_t   rdata_q;
	fb_client_e owner;            // Port user this cycle
	logic       acc;              // Any granted access
	logic       we_mux;
	fb_addr_t   addr_mux;
	fb_word_t   wdata_mux;

	always_comb begin
		owner         = cap_port.req ? CLIENT_CAPTURE : CLIENT_READOUT;  // Fixed priority
		cap_port.gnt  = cap_port.req;
		rd_port.gnt   = rd_port.req && !cap_port.req;
		acc           = cap_port.gnt || rd_port.gnt;
		we_mux        = (owner == CLIENT_CAPTURE) ? cap_port.we : rd_port.we;
		addr_mux      = (owner == CLIENT_CAPTURE) ? cap_port.addr : rd_port.addr;
		wdata_mux     = (owner == CLIENT_CAPTURE) ? cap_port.wdata : rd_port.wdata;
	end

	always_ff @(posedge clk_50) begin
		if (acc && we_mux)
			mem_q[addr_mux] <= wdata_mux;
		if (acc && !we_mux)
			rdata_q <= mem_q[addr_mux];  // One-cycle read latency
	end

	assign cap_port.rdata = rdata_q;    // Shared read bus
	assign rd_port.rdata  = rdata_q;

	// One owner per cycle and it matches the grant
	a_one_grant: assert property (@(posedge clk_50) disable iff (!rst_n)
		rd_port.gnt |-> (owner == CLIENT_READOUT) && !cap_port.gnt);

	// Granted accesses stay inside the frame
	a_addr_range: assert property (@(posedge clk_50) disable iff (!rst_n)
		acc |-> (int'(addr_mux) < `FB_DEPTH));

endmodule

//--- hw/mem_pkg.sv
// Frame buffer address, word and client types
`include "video_defs.svh"

package mem_pkg;

	typedef logic [`FB_ADDR_W-1:0] fb_addr_t; // One word per pixel
	typedef logic [11:0]           fb_word_t; // RGB444 as stored

	// Owner of the single memory port in a cycle
	typedef enum logic {
		CLIENT_CAPTURE = 1'b0, // Camera writer
		CLIENT_READOUT = 1'b1  // Frame reader
	} fb_client_e;

endpackage

//--- hw/ov7670_capture.sv
// OV7670 capture that packs camera byte pairs into RGB444 buffer writes
`include "video_defs.svh"

module ov7670_capture import video_pkg::*; import mem_pkg::*; (
	input  logic       clk_50,
	input  logic       rst_n,
	input  logic       vsync,      // High during blanking
	input  logic       href,       // Byte qualifier
	input  logic [7:0] data,
	fb_port_if.client  mem,
	output logic       frame_done  // One cycle after blanking starts
);

	localparam fb_addr_t LAST_ADDR = fb_addr_t'(`FRAME_W * `FRAME_H - 1);

	cam_word_u word_q;     // Byte view in, pixel view out
	logic      phase_q;    // Low byte expected next
	logic      wr_pend_q;  // Completed word awaiting write
	fb_addr_t  addr_q;     // Next pixel slot
	logic      vsync_q;
	logic      wrote_q;    // Frame has pixels
	logic      vsync_rise;
	logic      wr_fire;

	assign vsync_rise = vsync && !vsync_q;
	assign wr_fire    = mem.req && mem.gnt;  // Capture always wins

	assign mem.req   = wr_pend_q;
	assign mem.we    = 1'b1;                 // Write-only client
	assign mem.addr  = addr_q;
	assign mem.wdata = word_q.rgb.pix;       // Drop pad bits

	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			phase_q    <= 1'b0;
			wr_pend_q  <= 1'b0;
			addr_q     <= '0;
			vsync_q    <= 1'b0;
			wrote_q    <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			vsync_q   <= vsync;
			wr_pend_q <= href && phase_q && !vsync;  // Low byte just sampled
			if (vsync)
				phase_q <= 1'b0;                     // Realign in blanking
			else if (href)
				phase_q <= !phase_q;
			if (vsync_rise)
				addr_q <= '0;                        // New frame starts at 0
			else if (wr_fire)
				addr_q <= (addr_q == LAST_ADDR) ? '0 : addr_q + 1'b1;
			if (vsync_rise)
				wrote_q <= 1'b0;
			else if (wr_fire)
				wrote_q <= 1'b1;
			frame_done <= vsync_rise && (wrote_q || wr_fire);  // Skip empty frames
		end
	end

	always_ff @(posedge clk_50) begin
		if (href && !vsync) begin
			if (phase_q)
				word_q.bytes.lo <= data;
			else
				word_q.bytes.hi <= data;
		end
	end

	// Pixels only land outside vertical blanking
	a_no_write_in_blank: assert property (@(posedge clk_50) disable iff (!rst_n)
		!(mem.req && vsync));

endmodule

//--- hw/video_defs.svh
// Video path geometry, frame buffer sizing and filter threshold constants
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Frame geometry in pixels
`define FRAME_W 4
`define FRAME_H 2

// Frame buffer holds exactly one frame
`define FB_DEPTH (`FRAME_W * `FRAME_H)
`define FB_ADDR_W 3

// Threshold filter level on the 4-bit gray value
`define GRAY_THRESH 4'd8

`endif

//--- hw/video_ifs.sv
// Frame buffer client port and pixel stream interfaces
interface fb_port_if import mem_pkg::*; ();

	logic     req;   // Access request
	logic     we;    // Write when granted
	fb_addr_t addr;
	fb_word_t wdata;
	logic     gnt;   // Same-cycle grant
	fb_word_t rdata; // Valid one cycle after a granted read

	modport client (
		output req, we, addr, wdata,
		input  gnt, rdata
	);

	modport memory (
		input  req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

interface pix_stream_if import video_pkg::*; ();

	rgb444_t data;
	logic    sop;   // First pixel of a frame
	logic    eop;   // Last pixel of a frame
	logic    valid;
	logic    ready; // Beat moves on valid and ready

	modport source (output data, sop, eop, valid, input ready);

	modport sink (input data, sop, eop, valid, output ready);

endinterface

//--- hw/video_pkg.sv
// Pixel formats, camera word views and filter modes for the video path
package video_pkg;

	typedef struct packed {
		logic [3:0] r; // Red
		logic [3:0] g; // Green
		logic [3:0] b; // Blue
	} rgb444_t;

	// Camera word as it arrives with the high byte first
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} cam_bytes_t;

	// Same word read as RGB444 with four unused top bits
	typedef struct packed {
		logic [3:0] pad; // Ignored
		rgb444_t    pix;
	} cam_pix_t;

	typedef union packed {
		cam_bytes_t bytes; // Filled by capture
		cam_pix_t   rgb;   // Written to the buffer
	} cam_word_u;

	typedef enum logic [1:0] {
		FILT_PASS   = 2'd0, // Pixel unchanged
		FILT_GRAY   = 2'd1, // Luma on all channels
		FILT_INVERT = 2'd2, // Channel complement
		FILT_THRESH = 2'd3  // Black or white
	} filter_e;

endpackage

//--- verification/camera_filter_golden.txt
# Each line is one frame with the key index first, 4 for no key press
# Then eight pairs of raw camera word and expected output pixel in hex
4 a123 123 5fff fff 0000 000 c842 842 3e5a e5a f0f0 0f0 9777 777 6b1c b1c
1 0123 222 8fff fff 4000 000 2842 444 7e5a 888 10f0 777 d777 777 eb1c 666
2 0123 edc 1fff 000 2000 fff 3842 7bd 4e5a 1a5 50f0 f0f 6777 888 7b1c 4e3
3 8123 000 9fff fff a000 000 b842 000 ce5a fff d0f0 000 e888 fff f777 000
0 1456 456 2789 789 3abc abc 4def def 5012 012 6345 345 7678 678 89ab 9ab
2 0f00 0ff 0a5a 5a5 0321 cde 0fed 012 0111 eee 0c3c 3c3 0800 7ff 0abc 543
4 1000 fff 2fff 000 3123 edc 4456 ba9 5789 876 6abc 543 7def 210 8f0f 0f0
1 0f00 333 000f 333 00f0 777 0fff fff 0444 444 0a5a 777 0c3c 777 0123 222

//--- verification/camera_filter_tb.sv
// Testbench that replays golden camera frames and checks the filtered pixel stream
`include "video_defs.svh"

module camera_filter_tb;

	localparam int N_FRAMES       = 8;
	localparam int NPIX           = `FRAME_W * `FRAME_H;
	localparam int TIMEOUT_CYCLES = N_FRAMES * 200;  // Generous per-frame budget
	localparam int NO_KEY         = 4;               // Golden code for no press
	localparam int DRV_DLY        = 5;               // Input skew after the rising edge

	logic        clk_50;
	logic        rst_n;
	logic [3:0]  key;          // Active low
	logic        cam_vsync;
	logic        cam_href;
	logic [7:0]  cam_data;
	logic [11:0] pix_data;
	logic        pix_sop;
	logic        pix_eop;
	logic        pix_valid;
	logic        pix_ready;
	logic [1:0]  filter_mode;

	int          key_tab  [N_FRAMES];        // Key index per frame
	int          mode_tab [N_FRAMES];        // Mode active for the frame
	logic [15:0] cam_tab  [N_FRAMES][NPIX];  // Raw camera words
	logic [11:0] exp_tab  [N_FRAMES][NPIX];  // Expected output pixels
	integer      seed;
	int          cycle_cnt;

	camera_filter_top dut_i (.*);

	initial begin
		clk_50 = 1'b0;
		forever #20 clk_50 = ~clk_50;
	end

	task automatic end_with_failure();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic report_error(input string why);
		$display("error at %0t: %s", $time, why);
		end_with_failure();
	endtask

	task automatic report_mismatch(input string sig, input logic [15:0] got,
		input logic [15:0] want);
		$display("mismatch at %0t: %s got %0h expected %0h", $time, sig, got, want);
		end_with_failure();
	endtask

	// Run stops here if the DUT stalls for good
	always @(posedge clk_50) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			report_error("timeout before all frames came out");
	end

	task automatic step_cycle();
		@(posedge clk_50);
		#DRV_DLY;
	endtask

	task automatic press_key(input int k);
		step_cycle();
		key = ~(4'b0001 << k);
		repeat (2) step_cycle();  // Two cycles low
		key = 4'hf;
	endtask

	task automatic load_golden();
		int    fd;
		int    f;
		int    got;
		int    mode;
		string line;
		fd = $fopen("verification/camera_filter_golden.txt", "r");
		assert (fd != 0) else report_error("cannot open the golden file");
		f = 0;
		while (f < N_FRAMES && $fgets(line, fd) > 0) begin
			if (line.len() > 2 && line[0] != "#") begin  // Notes and blank lines
				got = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					key_tab[f], cam_tab[f][0], exp_tab[f][0], cam_tab[f][1], exp_tab[f][1],
					cam_tab[f][2], exp_tab[f][2], cam_tab[f][3], exp_tab[f][3],
					cam_tab[f][4], exp_tab[f][4], cam_tab[f][5], exp_tab[f][5],
					cam_tab[f][6], exp_tab[f][6], cam_tab[f][7], exp_tab[f][7]);
				assert (got == 17) else report_error("malformed frame line in the golden file");
				f++;
			end
		end
		$fclose(fd);
		assert (f == N_FRAMES) else report_error("golden file holds too few frames");
		mode = 0;                          // Pass after reset
		for (int i = 0; i < N_FRAMES; i++) begin
			if (key_tab[i] != NO_KEY)
				mode = key_tab[i];
			mode_tab[i] = mode;
		end
	endtask

	task automatic send_frame(input int f);
		step_cycle();
		cam_vsync = 1'b0;                  // Active lines
		for (int p = 0; p < NPIX; p++) begin
			step_cycle();
			assert (!pix_valid) else report_error("pix_valid high while a frame is captured");
			cam_href = 1'b1;
			cam_data = cam_tab[f][p][15:8];  // High byte first
			step_cycle();
			cam_href = 1'b0;                 // Idle between bytes
			step_cycle();
			cam_href = 1'b1;
			cam_data = cam_tab[f][p][7:0];
			step_cycle();
			cam_href = 1'b0;
		end
		step_cycle();
		cam_vsync = 1'b1;                  // Blanking ends the frame
	endtask

	task automatic check_beat(input int f, input int b);
		assert (pix_data === exp_tab[f][b])
			else report_mismatch("pix_data", pix_data, exp_tab[f][b]);
		assert (pix_sop === (b == 0))
			else report_mismatch("pix_sop", pix_sop, 16'(b == 0));
		assert (pix_eop === (b == NPIX - 1))
			else report_mismatch("pix_eop", pix_eop, 16'(b == NPIX - 1));
		if (b == 0) begin
			assert (filter_mode === 2'(mode_tab[f]))
				else report_mismatch("filter_mode", filter_mode, 16'(mode_tab[f]));
		end
	endtask

	task automatic collect_frame(input int f);
		int          beats;
		int          hold_cnt;   // Cycles left of a key press
		logic        stalled;
		logic [11:0] held_data;
		logic        held_sop;
		logic        held_eop;
		beats    = 0;
		hold_cnt = 0;
		stalled  = 1'b0;
		while (beats < NPIX || key != 4'hf) begin
			@(negedge clk_50);             // Outputs settled
			if (stalled) begin
				assert (pix_valid) else report_error("pix_valid dropped during a stall");
				assert (pix_data === held_data)
					else report_mismatch("pix_data", pix_data, held_data);
				assert (pix_sop === held_sop) else report_mismatch("pix_sop", pix_sop, held_sop);
				assert (pix_eop === held_eop) else report_mismatch("pix_eop", pix_eop, held_eop);
			end
			stalled   = pix_valid && !pix_ready;
			held_data = pix_data;
			held_sop  = pix_sop;
			held_eop  = pix_eop;
			if (pix_valid && pix_ready) begin
				assert (beats < NPIX) else report_error("extra beat after the end of the packet");
				check_beat(f, beats);
				if (beats == 0 && f + 1 < N_FRAMES && key_tab[f + 1] != NO_KEY)
					hold_cnt = 2;          // Next key lands mid-frame
				beats++;
			end
			step_cycle();
			pix_ready = ($random(seed) & 3) != 0;  // About one stall in four
			key       = (hold_cnt > 0) ? ~(4'b0001 << key_tab[f + 1]) : 4'hf;
			if (hold_cnt > 0)
				hold_cnt--;
		end
	endtask

	initial begin
		seed      = 32'h9929;
		cycle_cnt = 0;
		rst_n     = 1'b0;
		key       = 4'hf;                  // Released
		cam_vsync = 1'b1;                  // Start in blanking
		cam_href  = 1'b0;
		cam_data  = '0;
		pix_ready = 1'b0;
		load_golden();
		repeat (5) @(posedge clk_50);
		#DRV_DLY rst_n = 1'b1;
		if (key_tab[0] != NO_KEY)
			press_key(key_tab[0]);
		for (int f = 0; f < N_FRAMES; f++) begin
			send_frame(f);
			collect_frame(f);
		end
		repeat (10) begin
			@(negedge clk_50);
			assert (!pix_valid) else report_error("pix_valid rose after the last frame");
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule
